//--- src/ram_types_pkg.sv
// width types for the microcode, main and video memories; imported by the bus package and RTL
package ram_types_pkg;

   // --------------------
   // microcode store
   // --------------------

   // 16k words of writable control store
   typedef logic [13:0] mcr_addr_t;

   // one horizontal microinstruction
   typedef logic [48:0] mcr_word_t;

   // --------------------
   // main and video memory
   // --------------------

   // word address into main memory, 4M words addressable
   typedef logic [21:0] dram_addr_t;

   // word address into the frame buffer
   typedef logic [14:0] vram_addr_t;

   // data word for dram and vram
   typedef logic [31:0] data_word_t;

endpackage

//--- src/ram_bus_pkg.sv
// request and response structs for the three memory ports; imported by RTL and testbench
package ram_bus_pkg;

   import ram_types_pkg::*;

   // --------------------
   // microcode port
   // --------------------

   // write and prefetch share the same address
   typedef struct packed {
      mcr_addr_t addr;
      mcr_word_t wdata;
      logic      write;
      logic      prefetch;
   } mcr_req_t;

   // --------------------
   // main memory port
   // --------------------

   // strobes held until the matching ack pulse
   typedef struct packed {
      dram_addr_t addr;
      data_word_t wdata;
      logic       read;
      logic       write;
   } dram_req_t;

   // ready acks a read, done acks a write
   typedef struct packed {
      data_word_t rdata;
      logic       ready;
      logic       done;
   } dram_rsp_t;

   // --------------------
   // video memory, cpu side
   // --------------------

   typedef struct packed {
      vram_addr_t addr;
      data_word_t wdata;
      logic       read;
      logic       write;
   } vram_cpu_req_t;

   typedef struct packed {
      data_word_t rdata;
      logic       ready;
      logic       done;
   } vram_cpu_rsp_t;

endpackage

//--- src/microcode_ram.sv
// writable control store with one-cycle write ack and registered prefetch read
`timescale 1ns/100ps

module microcode_ram
   import ram_types_pkg::*, ram_bus_pkg::*;
#(
   parameter int MCR_DEPTH = 16384
)
(
   input  logic      clk,
   input  logic      reset,
   input  mcr_req_t  req,
   output mcr_word_t rdata,
   output logic      done
);

   mcr_word_t mem [MCR_DEPTH];
   mcr_word_t rdata_q;
   logic      done_q;

   // control store starts out cleared
   initial
   begin
      for (int i = 0; i < MCR_DEPTH; i++)
      begin
         mem[i] = '0;
      end
   end

   // --------------------
   // write path
   // --------------------

   always_ff @(posedge clk)
   begin
      if (req.write)
      begin
         mem[req.addr] <= req.wdata;
      end
   end

   // ack one cycle after each write cycle
   always_ff @(posedge clk)
   begin
      if (reset)
         done_q <= 1'b0;
      else
         done_q <= req.write;
   end

   // --------------------
   // prefetch path
   // --------------------

   // holds until the next prefetch
   always_ff @(posedge clk)
   begin
      if (reset)
         rdata_q <= '0;
      else if (req.prefetch)
         rdata_q <= mem[req.addr];
   end

   assign rdata = rdata_q;
   assign done  = done_q;

   // ack tracks the write strobe one cycle late
   a_done_follows_write: assert property (@(posedge clk)
      !reset && !$past(reset) |-> done == $past(req.write));

endmodule

//--- src/main_dram_model.sv
// main memory model with fixed-latency ack; one access in flight, extra requests wait
`timescale 1ns/100ps

module main_dram_model
   import ram_types_pkg::*, ram_bus_pkg::*;
#(
   parameter int DRAM_DEPTH = 131072,
   parameter int ACK_DELAY  = 8
)
(
   input  logic      clk,
   input  logic      reset,
   input  dram_req_t req,
   output dram_rsp_t rsp
);

   localparam int DRAM_AW = $clog2(DRAM_DEPTH);

   data_word_t           mem [DRAM_DEPTH];
   logic [ACK_DELAY:0]   ack_line;
   logic                 was_write;
   logic                 accept;
   logic                 in_range;
   logic                 ack_pulse;
   logic [DRAM_AW-1:0]   mem_idx;

   initial
   begin
      for (int i = 0; i < DRAM_DEPTH; i++)
      begin
         mem[i] = '0;
      end
   end

   // --------------------
   // address decode
   // --------------------

   // only the low part of the address space is populated
   assign in_range = (32'(req.addr) < 32'(DRAM_DEPTH));
   assign mem_idx  = req.addr[DRAM_AW-1:0];

   // new access only once the previous one has fully drained
   assign accept = (ack_line == '0) && (req.read || req.write);

   // --------------------
   // storage
   // --------------------

   // out of range writes are dropped
   always_ff @(posedge clk)
   begin
      if (accept && req.write && in_range)
      begin
         mem[mem_idx] <= req.wdata;
      end
   end

   // --------------------
   // ack shift line
   // --------------------

   // one extra stage past the pulse keeps a held strobe from restarting
   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         ack_line  <= '0;
         was_write <= 1'b0;
      end
      else
      begin
         ack_line <= {ack_line[ACK_DELAY-1:0], accept};
         if (accept)
            was_write <= req.write;
      end
   end

   assign ack_pulse = ack_line[ACK_DELAY-1];

   // read data follows the address directly
   assign rsp.rdata = in_range ? mem[mem_idx] : '1;
   assign rsp.ready = ack_pulse && !was_write;
   assign rsp.done  = ack_pulse && was_write;

   a_ack_exclusive: assert property (@(posedge clk) disable iff (reset)
      !(rsp.ready && rsp.done));

   // single access in flight
   a_one_in_flight: assert property (@(posedge clk) disable iff (reset)
      $onehot0(ack_line));

endmodule

//--- src/video_ram.sv
// frame buffer; cpu writes are parked until fetch and microcode write are idle
`timescale 1ns/100ps

module video_ram
   import ram_types_pkg::*, ram_bus_pkg::*;
#(
   parameter int VRAM_DEPTH = 21504
)
(
   input  logic          clk,
   input  logic          reset,
   input  logic          fetch,
   input  logic          mcr_busy,
   input  vram_cpu_req_t cpu_req,
   output vram_cpu_rsp_t cpu_rsp,
   input  vram_addr_t    vga_addr,
   output data_word_t    vga_rdata
);

   data_word_t mem [VRAM_DEPTH];

   // one parked write
   vram_addr_t pend_addr;
   data_word_t pend_data;
   logic       pend_valid;

   logic       commit;
   logic       done_q;
   logic       ready_q;

   initial
   begin
      for (int i = 0; i < VRAM_DEPTH; i++)
      begin
         mem[i] = '0;
      end
   end

   // --------------------
   // write buffer
   // --------------------

   // memory is free when neither fetch nor microcode write uses it
   assign commit = pend_valid && !fetch && !mcr_busy;

   always_ff @(posedge clk)
   begin
      if (cpu_req.write)
      begin
         pend_addr <= cpu_req.addr;
         pend_data <= cpu_req.wdata;
      end
   end

   // a new write wins over a same-cycle commit
   always_ff @(posedge clk)
   begin
      if (reset)
         pend_valid <= 1'b0;
      else if (cpu_req.write)
         pend_valid <= 1'b1;
      else if (commit)
         pend_valid <= 1'b0;
   end

   always_ff @(posedge clk)
   begin
      if (commit)
      begin
         mem[pend_addr] <= pend_data;
      end
   end

   // --------------------
   // handshakes
   // --------------------

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         done_q  <= 1'b0;
         ready_q <= 1'b0;
      end
      else
      begin
         done_q  <= commit;
         ready_q <= cpu_req.read;
      end
   end

   // both read ports look straight into the array
   assign cpu_rsp.rdata = mem[cpu_req.addr];
   assign cpu_rsp.ready = ready_q;
   assign cpu_rsp.done  = done_q;
   assign vga_rdata     = mem[vga_addr];

   a_done_after_pending: assert property (@(posedge clk) disable iff (reset)
      cpu_rsp.done |-> $past(pend_valid));

   // commit edge saw the array free
   a_commit_when_idle: assert property (@(posedge clk) disable iff (reset)
      cpu_rsp.done |-> !$past(fetch) && !$past(mcr_busy));

endmodule

//--- src/memory_controller_top.sv
// memory subsystem top; ties microcode, main and video memories to the processor ports
`timescale 1ns/100ps

module memory_controller_top
   import ram_types_pkg::*, ram_bus_pkg::*;
#(
   parameter int MCR_DEPTH  = 16384,
   parameter int DRAM_DEPTH = 131072,
   parameter int VRAM_DEPTH = 21504,
   parameter int ACK_DELAY  = 8
)
(
   input  logic          clk,
   input  logic          reset,
   input  logic          fetch,

   // microcode port
   input  mcr_req_t      mcr_req,
   output mcr_word_t     mcr_rdata,
   output logic          mcr_done,

   // main memory port
   input  dram_req_t     dram_req,
   output dram_rsp_t     dram_rsp,

   // video memory, cpu and display sides
   input  vram_cpu_req_t vram_cpu_req,
   output vram_cpu_rsp_t vram_cpu_rsp,
   input  vram_addr_t    vga_addr,
   output data_word_t    vga_rdata
);

   // microcode write ack, also holds off vram commits
   logic mcr_busy;

   // --------------------
   // microcode store
   // --------------------

   microcode_ram #(
      .MCR_DEPTH (MCR_DEPTH)
   ) mcr_i (
      .clk   (clk),
      .reset (reset),
      .req   (mcr_req),
      .rdata (mcr_rdata),
      .done  (mcr_busy)
   );

   assign mcr_done = mcr_busy;

   // --------------------
   // main memory
   // --------------------

   main_dram_model #(
      .DRAM_DEPTH (DRAM_DEPTH),
      .ACK_DELAY  (ACK_DELAY)
   ) dram_i (
      .clk   (clk),
      .reset (reset),
      .req   (dram_req),
      .rsp   (dram_rsp)
   );

   // --------------------
   // video memory
   // --------------------

   video_ram #(
      .VRAM_DEPTH (VRAM_DEPTH)
   ) vram_i (
      .clk       (clk),
      .reset     (reset),
      .fetch     (fetch),
      .mcr_busy  (mcr_busy),
      .cpu_req   (vram_cpu_req),
      .cpu_rsp   (vram_cpu_rsp),
      .vga_addr  (vga_addr),
      .vga_rdata (vga_rdata)
   );

endmodule

//--- test/memory_controller_checks.sv
// concurrent output checks that the testbench instantiates beside the DUT
`timescale 1ns/100ps

module memory_controller_checks
   import ram_types_pkg::*, ram_bus_pkg::*;
#(
   parameter int ACK_DELAY = 8
)
(
   input  logic          clk,
   input  logic          reset,
   input  logic          fetch,
   input  mcr_req_t      mcr_req,
   input  mcr_word_t     mcr_rdata,
   input  logic          mcr_done,
   input  dram_req_t     dram_req,
   input  dram_rsp_t     dram_rsp,
   input  vram_cpu_req_t vram_cpu_req,
   input  vram_cpu_rsp_t vram_cpu_rsp,
   input  data_word_t    vga_rdata,
   input  mcr_word_t     exp_mcr,
   input  data_word_t    exp_dram,
   input  data_word_t    exp_vram,
   input  data_word_t    exp_vga,
   input  logic          vga_check,
   output logic          error_seen
);

   logic       err_flag = 1'b0;
   logic [7:0] busy_cnt;
   logic       ref_write;
   logic       dram_strobe;
   logic       exp_pulse;
   logic       ref_pend;

   assign error_seen = err_flag;

   task automatic report(input string name, input logic [63:0] got, input logic [63:0] exp);
      $display("FAILED %s got %h expected %h", name, got, exp);
      err_flag = 1'b1;
   endtask

   // --------------------
   // dram timing model
   // --------------------

   // counts down the busy window of the accepted access
   assign dram_strobe = dram_req.read || dram_req.write;
   assign exp_pulse   = (busy_cnt == 8'd2);

   always_ff @(posedge clk)
   begin
      if (reset)
      begin
         busy_cnt  <= '0;
         ref_write <= 1'b0;
      end
      else if (busy_cnt == '0 && dram_strobe)
      begin
         busy_cnt  <= 8'(ACK_DELAY + 1);
         ref_write <= dram_req.write;
      end
      else if (busy_cnt != '0)
         busy_cnt <= busy_cnt - 8'd1;
   end

   // --------------------
   // vram write buffer model
   // --------------------

   // parked write leaves at the first edge with fetch and microcode ack low
   always_ff @(posedge clk)
   begin
      if (reset)
         ref_pend <= 1'b0;
      else if (vram_cpu_req.write)
         ref_pend <= 1'b1;
      else if (!fetch && !mcr_done)
         ref_pend <= 1'b0;
   end

   // --------------------
   // assertions
   // --------------------

   a_reset_quiet: assert property (@(posedge clk)
      $past(reset) |-> !mcr_done && mcr_rdata == '0 && !dram_rsp.ready && !dram_rsp.done
         && !vram_cpu_rsp.ready && !vram_cpu_rsp.done)
      else begin
         $display("outputs were not cleared by reset");
         err_flag = 1'b1;
      end

   a_mcr_done: assert property (@(posedge clk) disable iff (reset)
      mcr_done == $past(mcr_req.write))
      else report("mcr_done", 64'($sampled(mcr_done)), 64'(!$sampled(mcr_done)));

   // last prefetched word stays put between prefetches
   a_mcr_rdata: assert property (@(posedge clk) disable iff (reset)
      !mcr_req.prefetch |-> mcr_rdata == exp_mcr)
      else report("mcr_rdata", 64'($sampled(mcr_rdata)), 64'($sampled(exp_mcr)));

   a_dram_ready: assert property (@(posedge clk) disable iff (reset)
      dram_rsp.ready == (exp_pulse && !ref_write))
      else report("dram_rsp.ready", 64'($sampled(dram_rsp.ready)),
         64'($sampled(exp_pulse && !ref_write)));

   a_dram_done: assert property (@(posedge clk) disable iff (reset)
      dram_rsp.done == (exp_pulse && ref_write))
      else report("dram_rsp.done", 64'($sampled(dram_rsp.done)),
         64'($sampled(exp_pulse && ref_write)));

   a_dram_rdata: assert property (@(posedge clk) disable iff (reset)
      dram_rsp.ready |-> dram_rsp.rdata == exp_dram)
      else report("dram_rsp.rdata", 64'($sampled(dram_rsp.rdata)), 64'($sampled(exp_dram)));

   a_vram_ready: assert property (@(posedge clk) disable iff (reset)
      vram_cpu_rsp.ready == $past(vram_cpu_req.read))
      else report("vram_cpu_rsp.ready", 64'($sampled(vram_cpu_rsp.ready)),
         64'(!$sampled(vram_cpu_rsp.ready)));

   a_vram_rdata: assert property (@(posedge clk) disable iff (reset)
      vram_cpu_rsp.ready |-> vram_cpu_rsp.rdata == exp_vram)
      else report("vram_cpu_rsp.rdata", 64'($sampled(vram_cpu_rsp.rdata)),
         64'($sampled(exp_vram)));

   // done only right after the commit edge, never while the array is in use
   a_vram_done: assert property (@(posedge clk) disable iff (reset)
      vram_cpu_rsp.done == $past(ref_pend && !fetch && !mcr_done))
      else report("vram_cpu_rsp.done", 64'($sampled(vram_cpu_rsp.done)),
         64'(!$sampled(vram_cpu_rsp.done)));

   a_vga_rdata: assert property (@(posedge clk) disable iff (reset)
      vga_check |-> vga_rdata == exp_vga)
      else report("vga_rdata", 64'($sampled(vga_rdata)), 64'($sampled(exp_vga)));

endmodule

//--- test/memory_controller_tb.sv
// simulation top that drives the memory subsystem and keeps reference copies of its memories
`timescale 1ns/100ps

module memory_controller_tb
   import ram_types_pkg::*, ram_bus_pkg::*;
();

   localparam int MCR_DEPTH  = 16384;
   localparam int DRAM_DEPTH = 131072;
   localparam int VRAM_DEPTH = 21504;
   localparam int ACK_DELAY  = 8;
   localparam int TIMEOUT    = 64;

   logic          clk;
   logic          reset;
   logic          fetch;
   mcr_req_t      mcr_req;
   mcr_word_t     mcr_rdata;
   logic          mcr_done;
   dram_req_t     dram_req;
   dram_rsp_t     dram_rsp;
   vram_cpu_req_t vram_cpu_req;
   vram_cpu_rsp_t vram_cpu_rsp;
   vram_addr_t    vga_addr;
   data_word_t    vga_rdata;
   mcr_word_t     exp_mcr;
   data_word_t    exp_dram;
   data_word_t    exp_vram;
   data_word_t    exp_vga;
   logic          vga_check;
   logic          error_seen;
   int            seed = 32'h0491_670c;

   mcr_word_t  ref_mcr [MCR_DEPTH];
   data_word_t ref_dram [DRAM_DEPTH];
   data_word_t ref_vram [VRAM_DEPTH];

   memory_controller_top #(
      .MCR_DEPTH  (MCR_DEPTH),
      .DRAM_DEPTH (DRAM_DEPTH),
      .VRAM_DEPTH (VRAM_DEPTH),
      .ACK_DELAY  (ACK_DELAY)
   ) dut_i (.*);

   memory_controller_checks #(
      .ACK_DELAY (ACK_DELAY)
   ) checks_i (.*);

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   always @(posedge error_seen)
   begin
      $display("TEST FAILED");
      $fatal(1, "stopped at first check error");
   end

   task automatic timeout_fail(input string what);
      $display("wait for %s timed out", what);
      $display("TEST FAILED");
      $fatal(1, "timeout");
   endtask

   // --------------------
   // port sequences
   // --------------------

   task automatic mcr_write(input mcr_addr_t addr, input mcr_word_t data);
      ref_mcr[addr] = data;
      mcr_req.addr  = addr;
      mcr_req.wdata = data;
      mcr_req.write = 1'b1;
      @(negedge clk);
      mcr_req.write = 1'b0;
   endtask

   task automatic mcr_prefetch(input mcr_addr_t addr);
      exp_mcr          = ref_mcr[addr];
      mcr_req.addr     = addr;
      mcr_req.prefetch = 1'b1;
      @(negedge clk);
      mcr_req.prefetch = 1'b0;
      @(negedge clk);
   endtask

   // strobe held until its pulse has been sampled
   task automatic dram_access(input dram_addr_t addr, input data_word_t data, input logic wr);
      int   waited;
      logic in_range;
      in_range = int'(addr) < DRAM_DEPTH;
      if (wr && in_range)
         ref_dram[addr] = data;
      exp_dram       = in_range ? ref_dram[addr] : '1;
      dram_req.addr  = addr;
      dram_req.wdata = data;
      dram_req.read  = !wr;
      dram_req.write = wr;
      waited = 0;
      do
      begin
         @(negedge clk);
         waited++;
         if (waited > TIMEOUT)
            timeout_fail("dram acknowledge");
      end while (!(dram_rsp.ready || dram_rsp.done));
      @(negedge clk);
      dram_req.read  = 1'b0;
      dram_req.write = 1'b0;
   endtask

   // fetch held for hold cycles with a microcode write in the last one
   task automatic vram_write(input vram_addr_t addr, input data_word_t data, input int hold);
      int waited;
      ref_vram[addr]     = data;
      fetch              = (hold > 0);
      vram_cpu_req.addr  = addr;
      vram_cpu_req.wdata = data;
      vram_cpu_req.write = 1'b1;
      @(negedge clk);
      vram_cpu_req.write = 1'b0;
      for (int i = 0; i < hold; i++)
      begin
         if (i == hold - 1)
            mcr_write(mcr_addr_t'(i), mcr_word_t'(data));
         else
            @(negedge clk);
      end
      fetch  = 1'b0;
      waited = 0;
      while (!vram_cpu_rsp.done)
      begin
         @(negedge clk);
         waited++;
         if (waited > TIMEOUT)
            timeout_fail("vram write done");
      end
   endtask

   task automatic vram_read(input vram_addr_t addr);
      int waited;
      exp_vram          = ref_vram[addr];
      vram_cpu_req.addr = addr;
      vram_cpu_req.read = 1'b1;
      waited = 0;
      do
      begin
         @(negedge clk);
         waited++;
         if (waited > TIMEOUT)
            timeout_fail("vram read ready");
      end while (!vram_cpu_rsp.ready);
      vram_cpu_req.read = 1'b0;
      @(negedge clk);
   endtask

   task automatic vga_read(input vram_addr_t addr);
      vga_addr  = addr;
      exp_vga   = ref_vram[addr];
      vga_check = 1'b1;
      @(negedge clk);
      vga_check = 1'b0;
   endtask

   // --------------------
   // main sequence
   // --------------------

   initial
   begin
      mcr_addr_t  mcr_q [$];
      vram_addr_t vram_q [$];
      mcr_addr_t  ma;
      vram_addr_t va;
      dram_addr_t da;

      reset = 1'b1;
      fetch = 1'b0;
      mcr_req = '0;
      dram_req = '0;
      vram_cpu_req = '0;
      vga_addr = '0;
      exp_mcr = '0;
      exp_dram = '0;
      exp_vram = '0;
      exp_vga = '0;
      vga_check = 1'b0;
      foreach (ref_mcr[i]) ref_mcr[i] = '0;
      foreach (ref_dram[i]) ref_dram[i] = '0;
      foreach (ref_vram[i]) ref_vram[i] = '0;

      repeat (3) @(negedge clk);
      reset = 1'b0;
      repeat (2) @(negedge clk);

      for (int i = 0; i < 16; i++)
      begin
         ma = mcr_addr_t'($unsigned($random(seed)));
         mcr_write(ma, mcr_word_t'({$random(seed), $random(seed)}));
         mcr_q.push_back(ma);
      end
      foreach (mcr_q[i]) mcr_prefetch(mcr_q[i]);

      // isolated accesses with idle gaps
      for (int i = 0; i < 12; i++)
      begin
         da = dram_addr_t'($unsigned($random(seed)) % 64);
         dram_access(da, $random(seed), $random(seed) & 1);
         repeat (3) @(negedge clk);
      end

      // word 5 shares its low address bits with the dropped write
      dram_access(dram_addr_t'(5), 32'h1234_5678, 1'b1);
      dram_access(dram_addr_t'(DRAM_DEPTH + 5), 32'hdead_beef, 1'b1);
      dram_access(dram_addr_t'(DRAM_DEPTH + 5), '0, 1'b0);
      dram_access(dram_addr_t'(5), '0, 1'b0);

      // back to back requests each wait out the busy window
      for (int i = 0; i < 10; i++)
      begin
         da = dram_addr_t'($unsigned($random(seed)) % 64);
         dram_access(da, $random(seed), $random(seed) & 1);
      end

      for (int i = 0; i < 8; i++)
      begin
         va = vram_addr_t'($unsigned($random(seed)) % VRAM_DEPTH);
         vram_write(va, $random(seed), i % 4);
         vram_read(va);
         vram_q.push_back(va);
      end
      foreach (vram_q[i]) vga_read(vram_q[i]);

      repeat (3) @(negedge clk);
      if (error_seen)
      begin
         $display("TEST FAILED");
         $fatal(1, "check error at end of run");
      end
      else
      begin
         $display("TEST OK");
         $finish;
      end
   end

endmodule

//--- list.f
src/ram_types_pkg.sv
src/ram_bus_pkg.sv
src/microcode_ram.sv
src/main_dram_model.sv
src/video_ram.sv
src/memory_controller_top.sv
test/memory_controller_checks.sv
test/memory_controller_tb.sv

//--- run.sh
#!/bin/sh
# Builds and runs the memory subsystem testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
   --top-module memory_controller_tb \
   -f list.f

./obj_dir/Vmemory_controller_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "^TEST OK$" sim.log; then
   exit 0
fi
exit 1
